// File: Makefile
VERILATOR ?= verilator
TOP       := tb_cipher_ctrl
FILELIST  := sources.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: cipher_ctrl_macros.svh
/*
 * Sizing defines for the AES round sequencer
 * Sparse two-value width and its HIGH bit pattern
 * Round counter width and round counts per key length
 */

`ifndef CIPHER_CTRL_MACROS_SVH
`define CIPHER_CTRL_MACROS_SVH

// Sparse two-value encoding
`define CIPH_SP2V_WIDTH 3
`define CIPH_SP2V_HIGH_BITS 3'b011 // Bit value per rail, sets its polarity

// Round counter
`define CIPH_RND_WIDTH 4

// Rounds per key length
`define CIPH_NR_128 4'd10
`define CIPH_NR_192 4'd12
`define CIPH_NR_256 4'd14

`endif

// File: cipher_ctrl_pkg.sv
/*
 * Types for the AES round sequencer
 * Sparse two-value enum, key length, sparse selects
 * Rail control word as field struct and raw union
 */

`default_nettype none

`include "cipher_ctrl_macros.svh"

package cipher_ctrl_pkg;

  // Sparse valid/ready, any other pattern is an encoding error
  typedef enum logic [`CIPH_SP2V_WIDTH-1:0] {
    SP2V_HIGH = `CIPH_SP2V_HIGH_BITS,
    SP2V_LOW  = ~(`CIPH_SP2V_HIGH_BITS)
  } sp2v_e;

  typedef enum logic [1:0] {
    AES_128 = 2'b01,
    AES_192 = 2'b10,
    AES_256 = 2'b11 // 2'b00 is not a key length
  } key_len_e;

  // State register input mux, Hamming distance 2
  typedef enum logic [`CIPH_SP2V_WIDTH-1:0] {
    STATE_IDLE  = 3'b011,
    STATE_INIT  = 3'b101,
    STATE_ROUND = 3'b110
  } state_sel_e;

  typedef enum logic [`CIPH_SP2V_WIDTH-1:0] {
    ADD_RK_INIT  = 3'b011,
    ADD_RK_ROUND = 3'b101,
    ADD_RK_FINAL = 3'b110
  } add_rk_sel_e;

  typedef struct packed {
    state_sel_e                 state_sel;
    add_rk_sel_e                add_rk_sel;
    logic                       state_we;
    logic [`CIPH_RND_WIDTH-1:0] round;
  } ctrl_fields_s;

  localparam int unsigned CtrlWidth = $bits(ctrl_fields_s);

  // Fields for decoding, raw bits for OR-combining and compare
  typedef union packed {
    ctrl_fields_s         fields;
    logic [CtrlWidth-1:0] raw;
  } ctrl_word_u;

endpackage

`default_nettype wire

// File: cipher_ctrl_rail.sv
/*
 * One rail of the redundant AES round sequencer
 * Round FSM with round counter and terminal error state
 * Polarity selects active-high or active-low handshake bits
 */

`timescale 1ns/100ps
`default_nettype none

`include "cipher_ctrl_macros.svh"

module cipher_ctrl_rail import cipher_ctrl_pkg::*; #(
  parameter bit Polarity = 1'b1 // 1: bit value 1 is active
) (
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     in_valid_bit_i,
  input  logic     out_ready_bit_i,
  input  key_len_e key_len_i,
  input  logic     enc_err_i,

  rail_if.rail     rail
);

  typedef enum logic [2:0] {
    IDLE,
    INIT,
    ROUND,
    FINAL,
    DONE,
    ERROR
  } rail_state_e;

  rail_state_e                state_d, state_q;
  logic [`CIPH_RND_WIDTH-1:0] rnd_ctr_d, rnd_ctr_q;
  logic [`CIPH_RND_WIDTH-1:0] nr_d, nr_q;
  logic [`CIPH_RND_WIDTH-1:0] nr_sel;
  logic                       in_valid, out_ready;
  logic                       in_ready, out_valid;
  logic                       alert;
  ctrl_word_u                 ctrl;

  // Handshake bits into active-high form
  assign in_valid  = Polarity ? in_valid_bit_i : ~in_valid_bit_i;
  assign out_ready = Polarity ? out_ready_bit_i : ~out_ready_bit_i;

  always_comb begin : nr_decode
    case (key_len_i)
      AES_192: nr_sel = `CIPH_NR_192;
      AES_256: nr_sel = `CIPH_NR_256;
      default: nr_sel = `CIPH_NR_128;
    endcase
  end

  //////////////////////////////////////////////////
  // Round FSM
  //////////////////////////////////////////////////

  always_comb begin : fsm_next
    state_d   = state_q;
    rnd_ctr_d = rnd_ctr_q;
    nr_d      = nr_q;
    in_ready  = 1'b0;
    out_valid = 1'b0;
    alert     = 1'b0;

    ctrl.fields.state_sel  = STATE_IDLE;
    ctrl.fields.add_rk_sel = ADD_RK_INIT;
    ctrl.fields.state_we   = 1'b0;
    ctrl.fields.round      = rnd_ctr_q;

    case (state_q)
      IDLE: begin
        in_ready = 1'b1;
        if (in_valid) begin
          state_d   = INIT;
          rnd_ctr_d = '0;
          nr_d      = nr_sel; // Key length sampled here
        end
      end
      INIT: begin
        ctrl.fields.state_sel = STATE_INIT;
        ctrl.fields.state_we  = 1'b1;
        rnd_ctr_d             = rnd_ctr_q + 1'b1;
        state_d               = ROUND;
      end
      ROUND: begin
        ctrl.fields.state_sel  = STATE_ROUND;
        ctrl.fields.add_rk_sel = ADD_RK_ROUND;
        ctrl.fields.state_we   = 1'b1;
        rnd_ctr_d              = rnd_ctr_q + 1'b1;
        if (rnd_ctr_q == nr_q - `CIPH_RND_WIDTH'(1)) begin
          state_d = FINAL; // Next round is Nr
        end
      end
      FINAL: begin
        ctrl.fields.state_sel  = STATE_ROUND;
        ctrl.fields.add_rk_sel = ADD_RK_FINAL;
        ctrl.fields.state_we   = 1'b1;
        state_d                = DONE;
      end
      DONE: begin
        out_valid = 1'b1; // Held under back-pressure
        if (out_ready) begin
          state_d   = IDLE;
          rnd_ctr_d = '0;
        end
      end
      ERROR: begin
        alert = 1'b1; // Terminal until reset
      end
      default: state_d = ERROR;
    endcase

    // Bad input code or disagreement between rails
    if (enc_err_i || rail.err) begin
      state_d = ERROR;
    end
  end

  always_ff @(posedge clk_i) begin : fsm_regs
    if (!rst_ni) begin
      state_q   <= IDLE;
      rnd_ctr_q <= '0;
      nr_q      <= `CIPH_NR_128;
    end else begin
      state_q   <= state_d;
      rnd_ctr_q <= rnd_ctr_d;
      nr_q      <= nr_d;
    end
  end

  // Back to rail polarity
  assign rail.in_ready_bit  = Polarity ? in_ready : ~in_ready;
  assign rail.out_valid_bit = Polarity ? out_valid : ~out_valid;
  assign rail.alert         = alert;
  assign rail.ctrl          = ctrl;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  rnd_ctr_max_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) rnd_ctr_q <= nr_q
  ) else $error("Round counter beyond Nr");

  error_sticky_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) (state_q == ERROR) |=> (state_q == ERROR)
  ) else $error("Rail left ERROR without reset");

endmodule

`default_nettype wire

// File: cipher_ctrl_top.sv
/*
 * Top level of the redundant AES round sequencer
 * Input checker, three single-bit rails, output combiner
 */

`timescale 1ns/100ps
`default_nettype none

`include "cipher_ctrl_macros.svh"

module cipher_ctrl_top import cipher_ctrl_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  sp2v_e                      in_valid_i,
  output sp2v_e                      in_ready_o,
  input  key_len_e                   key_len_i,

  output sp2v_e                      out_valid_o,
  input  sp2v_e                      out_ready_i,

  output state_sel_e                 state_sel_o,
  output add_rk_sel_e                add_rk_sel_o,
  output logic                       state_we_o,
  output logic [`CIPH_RND_WIDTH-1:0] round_o,
  output logic                       alert_o
);

  // Bit i of the HIGH code gives the polarity of rail i
  localparam logic [`CIPH_SP2V_WIDTH-1:0] SpHighBits = `CIPH_SP2V_HIGH_BITS;

  logic [`CIPH_SP2V_WIDTH-1:0] in_valid_bits;
  logic [`CIPH_SP2V_WIDTH-1:0] out_ready_bits;
  logic                        enc_err;

  rail_if rail_bus [`CIPH_SP2V_WIDTH] ();

  sp2v_checker i_sp2v_checker (
    .clk_i            ( clk_i          ),
    .rst_ni           ( rst_ni         ),
    .in_valid_i       ( in_valid_i     ),
    .out_ready_i      ( out_ready_i    ),
    .key_len_i        ( key_len_i      ),
    .in_valid_bits_o  ( in_valid_bits  ),
    .out_ready_bits_o ( out_ready_bits ),
    .enc_err_o        ( enc_err        )
  );

  // One rail per bit of the sparse code
  for (genvar i = 0; i < `CIPH_SP2V_WIDTH; i++) begin : gen_rail
    cipher_ctrl_rail #(
      .Polarity ( SpHighBits[i] )
    ) i_cipher_ctrl_rail (
      .clk_i           ( clk_i             ),
      .rst_ni          ( rst_ni            ),
      .in_valid_bit_i  ( in_valid_bits[i]  ), // Sparsified
      .out_ready_bit_i ( out_ready_bits[i] ), // Sparsified
      .key_len_i       ( key_len_i         ),
      .enc_err_i       ( enc_err           ),
      .rail            ( rail_bus[i]       )
    );
  end

  rail_combiner i_rail_combiner (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .rails        ( rail_bus     ),
    .in_ready_o   ( in_ready_o   ),
    .out_valid_o  ( out_valid_o  ),
    .state_sel_o  ( state_sel_o  ),
    .add_rk_sel_o ( add_rk_sel_o ),
    .state_we_o   ( state_we_o   ),
    .round_o      ( round_o      ),
    .alert_o      ( alert_o      )
  );

endmodule

`default_nettype wire

// File: rail_combiner.sv
/*
 * Output side of the round sequencer
 * OR-combines the rail control words and flags mismatch
 * Rebuilds the sparse handshake outputs and the alert
 */

`timescale 1ns/100ps
`default_nettype none

`include "cipher_ctrl_macros.svh"

module rail_combiner import cipher_ctrl_pkg::*; (
  input  logic                       clk_i,  // Assertions only
  input  logic                       rst_ni, // Assertions only

  rail_if.combiner                   rails [`CIPH_SP2V_WIDTH],

  output sp2v_e                      in_ready_o,
  output sp2v_e                      out_valid_o,
  output state_sel_e                 state_sel_o,
  output add_rk_sel_e                add_rk_sel_o,
  output logic                       state_we_o,
  output logic [`CIPH_RND_WIDTH-1:0] round_o,
  output logic                       alert_o
);

  ctrl_word_u [`CIPH_SP2V_WIDTH-1:0] mr_ctrl;
  logic       [`CIPH_SP2V_WIDTH-1:0] mr_in_ready;
  logic       [`CIPH_SP2V_WIDTH-1:0] mr_out_valid;
  logic       [`CIPH_SP2V_WIDTH-1:0] mr_alert;
  ctrl_word_u                        comb_ctrl;
  logic                              mr_err;
  logic                              sel_err;

  for (genvar i = 0; i < `CIPH_SP2V_WIDTH; i++) begin : gen_collect
    assign mr_ctrl[i]      = rails[i].ctrl;
    assign mr_in_ready[i]  = rails[i].in_ready_bit;  // Sparsified
    assign mr_out_valid[i] = rails[i].out_valid_bit; // Sparsified
    assign mr_alert[i]     = rails[i].alert;         // OR-combine
    assign rails[i].err    = mr_err | sel_err;       // Every rail goes to ERROR
  end

  //////////////////////////////////////////////////
  // Control word
  //////////////////////////////////////////////////

  // A single set bit on one rail shows up in the OR and in the compare
  always_comb begin : combine_ctrl
    comb_ctrl.raw = '0;
    mr_err        = 1'b0;
    for (int i = 0; i < `CIPH_SP2V_WIDTH; i++) begin
      comb_ctrl.raw = comb_ctrl.raw | mr_ctrl[i].raw;
    end
    for (int i = 0; i < `CIPH_SP2V_WIDTH; i++) begin
      if (mr_ctrl[i].raw != comb_ctrl.raw) begin
        mr_err = 1'b1;
      end
    end
  end

  // Combined selects must still be legal codes
  assign sel_err =
      !(comb_ctrl.fields.state_sel inside {STATE_IDLE, STATE_INIT, STATE_ROUND}) ||
      !(comb_ctrl.fields.add_rk_sel inside {ADD_RK_INIT, ADD_RK_ROUND, ADD_RK_FINAL});

  assign state_sel_o  = comb_ctrl.fields.state_sel;
  assign add_rk_sel_o = comb_ctrl.fields.add_rk_sel;
  assign state_we_o   = comb_ctrl.fields.state_we;
  assign round_o      = comb_ctrl.fields.round;

  // Handshake outputs, HIGH only if all rails agree
  assign in_ready_o  = sp2v_e'(mr_in_ready);
  assign out_valid_o = sp2v_e'(mr_out_valid);
  assign alert_o     = |mr_alert;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Any rail in ERROR breaks the HIGH code of out_valid
  no_valid_on_alert_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) alert_o |-> (out_valid_o != SP2V_HIGH)
  ) else $error("out_valid_o HIGH while alert_o is set");

endmodule

`default_nettype wire

// File: rail_if.sv
/*
 * Outputs of one sequencer rail towards the combiner
 * Mismatch error back to the rail
 */

`timescale 1ns/100ps
`default_nettype none

interface rail_if import cipher_ctrl_pkg::*; ();

  ctrl_word_u ctrl;          // Same on every healthy rail
  logic       in_ready_bit;  // Rail polarity
  logic       out_valid_bit; // Rail polarity
  logic       alert;
  logic       err;           // Mismatch or bad select seen by combiner

  modport rail (
    output ctrl,
    output in_ready_bit,
    output out_valid_bit,
    output alert,
    input  err
  );

  modport combiner (
    input  ctrl,
    input  in_ready_bit,
    input  out_valid_bit,
    input  alert,
    output err
  );

endinterface

`default_nettype wire

// File: sources.f
+incdir+.
cipher_ctrl_pkg.sv
rail_if.sv
sp2v_checker.sv
cipher_ctrl_rail.sv
rail_combiner.sv
cipher_ctrl_top.sv
tb_cipher_ctrl.sv

// File: sp2v_checker.sv
/*
 * Input side of the round sequencer
 * Sparse encoding check of in_valid and out_ready
 * Split into per-rail bits
 */

`timescale 1ns/100ps
`default_nettype none

`include "cipher_ctrl_macros.svh"

module sp2v_checker import cipher_ctrl_pkg::*; (
  input  logic                        clk_i,  // Assertions only
  input  logic                        rst_ni, // Assertions only

  input  sp2v_e                       in_valid_i,
  input  sp2v_e                       out_ready_i,
  input  key_len_e                    key_len_i,

  output logic [`CIPH_SP2V_WIDTH-1:0] in_valid_bits_o,
  output logic [`CIPH_SP2V_WIDTH-1:0] out_ready_bits_o,
  output logic                        enc_err_o
);

  logic in_valid_err;
  logic out_ready_err;

  // Only the two sparse codes are legal
  assign in_valid_err  = !(in_valid_i inside {SP2V_HIGH, SP2V_LOW});
  assign out_ready_err = !(out_ready_i inside {SP2V_HIGH, SP2V_LOW});

  assign enc_err_o = in_valid_err | out_ready_err;

  // Raw bits go on unchanged, a bad code makes the rails diverge as well
  assign in_valid_bits_o  = in_valid_i;
  assign out_ready_bits_o = out_ready_i;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Rails load Nr from the key length on a start
  key_len_legal_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (in_valid_i == SP2V_HIGH) |-> (key_len_i inside {AES_128, AES_192, AES_256})
  ) else $error("key_len_i is not a legal key length on a start");

endmodule

`default_nettype wire

// File: tb_cipher_ctrl.sv
/*
 * Testbench for the redundant AES round sequencer
 * Clock, reset, LFSR stimulus and round reference model
 * Handshake, back-pressure and encoding error checks
 */

`timescale 1ns/100ps
`default_nettype none

`include "cipher_ctrl_macros.svh"

module tb_cipher_ctrl import cipher_ctrl_pkg::*; ();

  localparam int unsigned WaitLimit = 64; // Cycles before a wait gives up
  localparam int unsigned NumRuns   = 16;

  logic                       clk;
  logic                       rst_n;
  sp2v_e                      in_valid;
  sp2v_e                      in_ready;
  key_len_e                   key_len;
  sp2v_e                      out_valid;
  sp2v_e                      out_ready;
  state_sel_e                 state_sel;
  add_rk_sel_e                add_rk_sel;
  logic                       state_we;
  logic [`CIPH_RND_WIDTH-1:0] round;
  logic                       alert;
  logic [15:0]                lfsr;

  cipher_ctrl_top i_cipher_ctrl_top (
    .clk_i        ( clk        ),
    .rst_ni       ( rst_n      ),
    .in_valid_i   ( in_valid   ),
    .in_ready_o   ( in_ready   ),
    .key_len_i    ( key_len    ),
    .out_valid_o  ( out_valid  ),
    .out_ready_i  ( out_ready  ),
    .state_sel_o  ( state_sel  ),
    .add_rk_sel_o ( add_rk_sel ),
    .state_we_o   ( state_we   ),
    .round_o      ( round      ),
    .alert_o      ( alert      )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic report_error(input string msg);
    $display("Fail %0t: %s", $time, msg);
    $display("Test failures found");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("Test failures found");
    $fatal(1, "Stopped on timeout");
  endtask

  // 16-bit Galois LFSR, taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int unsigned n, output int unsigned val);
    int unsigned i;
    val = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = (val << 1) | lfsr[0]; // One step per bit
    end
  endtask

  function automatic key_len_e key_from_bits(input int unsigned v);
    case (v)
      1:       key_from_bits = AES_192;
      2:       key_from_bits = AES_256;
      default: key_from_bits = AES_128;
    endcase
  endfunction

  function automatic int unsigned rounds_for(input key_len_e kl);
    case (kl)
      AES_192: rounds_for = `CIPH_NR_192;
      AES_256: rounds_for = `CIPH_NR_256;
      default: rounds_for = `CIPH_NR_128;
    endcase
  endfunction

  // Expected selects for the cycle cyc after acceptance
  function automatic void model_round(input int unsigned nr, input int unsigned cyc,
                                      output state_sel_e sel, output add_rk_sel_e rk);
    if (cyc == 0) begin
      sel = STATE_INIT;
      rk  = ADD_RK_INIT;
    end else begin
      sel = STATE_ROUND;
      rk  = (cyc == nr) ? ADD_RK_FINAL : ADD_RK_ROUND;
    end
  endfunction

  // Any 3-bit value that is neither sparse code
  function automatic logic [2:0] bad_code(input logic [2:0] v);
    bad_code = (v == SP2V_HIGH || v == SP2V_LOW) ? (v ^ 3'b001) : v;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    @(negedge clk); // Outputs settled, inputs change here
  endtask

  task automatic apply_reset();
    rst_n     = 1'b0;
    in_valid  = SP2V_LOW;
    out_ready = SP2V_LOW;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic check_idle();
    assert (in_ready == SP2V_HIGH) else report_error("in_ready_o not HIGH while idle");
    assert (out_valid == SP2V_LOW) else report_error("out_valid_o not LOW while idle");
    assert (state_we == 1'b0) else report_error("state_we_o set while idle");
    assert (alert == 1'b0) else report_error("alert_o set while idle");
    assert (state_sel == STATE_IDLE) else report_error("state_sel_o not STATE_IDLE");
  endtask

  task automatic check_locked();
    assert (alert == 1'b1) else report_error("alert_o not set after encoding error");
    assert (in_ready == SP2V_LOW) else report_error("in_ready_o not LOW in error");
    assert (out_valid == SP2V_LOW) else report_error("out_valid_o not LOW in error");
    assert (state_we == 1'b0) else report_error("state_we_o set in error");
  endtask

  // Error state must survive starts and ready until the next reset
  task automatic hold_locked();
    check_locked();
    in_valid  = SP2V_HIGH;
    out_ready = SP2V_HIGH;
    repeat (8) begin
      next_cycle();
      check_locked();
    end
    apply_reset();
    check_idle();
  endtask

  task automatic wait_ready();
    int unsigned n;
    n = 0;
    while (in_ready != SP2V_HIGH) begin
      if (n == WaitLimit) report_timeout("in_ready_o");
      next_cycle();
      n++;
    end
  endtask

  //////////////////////////////////////////////////
  // One start-to-completion run
  //////////////////////////////////////////////////

  task automatic run_block(input logic bad_ready);
    key_len_e    kl;
    state_sel_e  exp_sel;
    add_rk_sel_e exp_rk;
    int unsigned v;
    int unsigned nr;
    int unsigned cyc;
    int unsigned stall;
    int unsigned i;
    take_bits(2, v);
    kl = key_from_bits(v);
    nr = rounds_for(kl);
    wait_ready();
    in_valid = SP2V_HIGH;
    key_len  = kl;
    next_cycle(); // Acceptance edge
    in_valid = SP2V_LOW;
    cyc      = 0;
    while (out_valid != SP2V_HIGH) begin
      if (cyc == WaitLimit) report_timeout("out_valid_o");
      assert (cyc <= nr) else report_error("out_valid_o late after the final round");
      model_round(nr, cyc, exp_sel, exp_rk);
      assert (state_sel == exp_sel)
        else report_error($sformatf("state_sel_o %0h in round %0d", state_sel, cyc));
      assert (add_rk_sel == exp_rk)
        else report_error($sformatf("add_rk_sel_o %0h in round %0d", add_rk_sel, cyc));
      assert (round == `CIPH_RND_WIDTH'(cyc))
        else report_error($sformatf("round_o %0d, expected %0d", round, cyc));
      assert (state_we == 1'b1) else report_error("state_we_o low during a round");
      assert (in_ready == SP2V_LOW) else report_error("in_ready_o not LOW while busy");
      assert (out_valid == SP2V_LOW) else report_error("out_valid_o not LOW while busy");
      assert (alert == 1'b0) else report_error("alert_o set during a run");
      next_cycle();
      cyc++;
    end
    assert (cyc == nr + 1)
      else report_error($sformatf("out_valid_o after %0d edges, expected %0d", cyc, nr + 1));
    assert (in_ready == SP2V_LOW) else report_error("in_ready_o not LOW with out_valid_o HIGH");
    assert (state_we == 1'b0) else report_error("state_we_o set with out_valid_o HIGH");

    if (bad_ready) begin
      take_bits(3, v);
      out_ready = sp2v_e'(bad_code(v[2:0]));
      next_cycle();
      out_ready = SP2V_LOW;
      hold_locked();
    end else begin
      take_bits(3, stall);
      out_ready = SP2V_LOW;
      for (i = 0; i < stall; i++) begin
        in_valid = SP2V_HIGH; // Start offered under back-pressure
        next_cycle();
        assert (out_valid == SP2V_HIGH) else report_error("out_valid_o dropped in stall");
        assert (in_ready == SP2V_LOW) else report_error("start accepted during stall");
        assert (state_we == 1'b0) else report_error("state_we_o set during stall");
      end
      in_valid  = SP2V_LOW;
      out_ready = SP2V_HIGH;
      next_cycle(); // Completion edge
      out_ready = SP2V_LOW;
      check_idle();
    end
  endtask

  task automatic check_bad_in_valid();
    int unsigned v;
    take_bits(3, v);
    in_valid = sp2v_e'(bad_code(v[2:0]));
    next_cycle();
    in_valid = SP2V_LOW;
    hold_locked();
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int unsigned run;
    int unsigned gap;
    rst_n     = 1'b0;
    in_valid  = SP2V_LOW;
    out_ready = SP2V_LOW;
    key_len   = AES_128;
    lfsr      = 16'd39;
    apply_reset();
    check_idle();
    for (run = 0; run < NumRuns; run++) begin
      run_block(1'b0);
      take_bits(2, gap);
      repeat (gap) begin // Idle gap between starts
        next_cycle();
        check_idle();
      end
    end
    check_bad_in_valid();
    run_block(1'b1); // Bad out_ready code while out_valid is held
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire
